//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_l1_wb_bridge
FILELIST := vlog.f
BIN      := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	$(SIM) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- src/fifo_if.sv
// *************************************************************************
// Queue interface
// Push/full on the write side, valid/pop on the read side
// *************************************************************************

`timescale 1ns/1ps

interface fifo_if #(
    parameter type payload_t = logic
) ();

    logic     push;        // Producer writes data_in this cycle
    payload_t data_in;     // Entry to store
    logic     full;        // No room, push is not allowed
    logic     valid;       // data_out holds a live entry
    payload_t data_out;    // Head of the queue
    logic     pop;         // Consumer drops the head this cycle

    // Requester side
    modport producer (
        output push,
        output data_in,
        input  full
    );

    // Engine side, head is always visible
    modport consumer (
        output pop,
        input  valid,
        input  data_out
    );

    // The queue itself
    modport storage (
        input  push,
        input  data_in,
        input  pop,
        output full,
        output valid,
        output data_out
    );

endinterface

//--- src/l1_wb_bridge.sv
// *************************************************************************
// L1-to-Wishbone bridge top
// Queues requests and write beats, then runs them on Wishbone
// *************************************************************************

`timescale 1ns/1ps

`include "l2_bridge_defs.svh"

module l1_wb_bridge
    import l2_bridge_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    // Requester, request stream
    input  logic                    req_push,
    input  logic [`L2_ADDR_W-1:0]   req_addr,
    input  logic                    req_rnw,
    input  logic [`L2_BURST_W-1:0]  req_burst_size,
    input  logic [`L2_SUB_ID_W-1:0] req_sub_id,
    output logic                    req_full,
    // Requester, write-data stream
    input  logic                    wr_push,
    input  logic [`L2_DATA_W-1:0]   wr_data,
    input  logic [`L2_BE_W-1:0]     wr_be,
    output logic                    wr_full,
    // Read return
    output logic                    rd_valid,
    output logic [`L2_DATA_W-1:0]   rd_data,
    output logic [`L2_SUB_ID_W-1:0] rd_sub_id,
    // Wishbone master
    output logic                    cyc,
    output logic                    stb,
    output logic                    we,
    output logic [`L2_ADDR_W-1:0]   adr,
    output logic [`L2_BE_W-1:0]     sel,
    output logic [`L2_DATA_W-1:0]   dat_w,
    input  logic                    ack,
    input  logic [`L2_DATA_W-1:0]   dat_r
);

    fifo_if #(.payload_t(l2_request_t)) req_q ();
    fifo_if #(.payload_t(l2_wr_data_t)) wd_q ();

    l2_request_t   req_in;
    l2_wr_data_t   wd_in;
    l2_rd_return_t rd_ret;

    // Pack the request fields
    assign req_in.addr       = req_addr;
    assign req_in.rnw        = req_rnw;
    assign req_in.burst_size = req_burst_size;
    assign req_in.sub_id     = req_sub_id;

    assign req_q.push    = req_push;
    assign req_q.data_in = req_in;
    assign req_full      = req_q.full;

    assign wd_in.data   = wr_data;
    assign wd_in.be     = wr_be;
    assign wd_q.push    = wr_push;
    assign wd_q.data_in = wd_in;
    assign wr_full      = wd_q.full;

    req_fifo #(.payload_t(l2_request_t), .DEPTH(`L2_FIFO_DEPTH)) u_req_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .q     (req_q.storage)
    );

    req_fifo #(.payload_t(l2_wr_data_t), .DEPTH(`L2_FIFO_DEPTH)) u_wd_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .q     (wd_q.storage)
    );

    wb_burst_master u_burst_master (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req_q.consumer),
        .wd           (wd_q.consumer),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .sel          (sel),
        .dat_w        (dat_w),
        .ack          (ack),
        .dat_r        (dat_r),
        .rd_ret       (rd_ret),
        .rd_ret_valid (rd_valid)
    );

    assign rd_data   = rd_ret.data;     // Unpack the return
    assign rd_sub_id = rd_ret.sub_id;

endmodule

//--- src/l2_bridge_defs.svh
// *************************************************************************
// L1-to-Wishbone bridge widths and depths
// Shared sizing macros for the request queues and the bus side
// *************************************************************************

`ifndef L2_BRIDGE_DEFS_SVH
`define L2_BRIDGE_DEFS_SVH

// Word-addressed bus, so no byte offset bits here
`define L2_ADDR_W 30                 // Word address width

`define L2_DATA_W 32                 // Bus data width
`define L2_BE_W 4                    // One enable per data byte

// Burst size is a low-bit mask, beats = mask + 1
`define L2_BURST_W 5                 // Covers up to 32-word blocks

`define L2_SUB_ID_W 2                // Requester tag returned with reads

`define L2_FIFO_DEPTH 32             // Default entries per queue

`endif

//--- src/l2_bridge_pkg.sv
// *************************************************************************
// L1-to-Wishbone bridge types
// Payloads for the request queue, write-data queue and read return
// *************************************************************************

`include "l2_bridge_defs.svh"

package l2_bridge_pkg;

    // One queued request from the L1 side
    typedef struct packed {
        logic [`L2_ADDR_W-1:0]   addr;       // Starting word of the burst
        logic                    rnw;        // High for read
        logic [`L2_BURST_W-1:0]  burst_size; // Mask 0/1/3/7/15/31
        logic [`L2_SUB_ID_W-1:0] sub_id;     // Echoed on read return
    } l2_request_t;

    // One write beat, consumed in burst order
    typedef struct packed {
        logic [`L2_DATA_W-1:0] data;       // Write word
        logic [`L2_BE_W-1:0]   be;         // Byte enables for this beat
    } l2_wr_data_t;

    // One read beat handed back to the requester
    typedef struct packed {
        logic [`L2_DATA_W-1:0]   data;     // Word from the slave
        logic [`L2_SUB_ID_W-1:0] sub_id;   // Tag of the owning request
    } l2_rd_return_t;

    // Beat count of a burst mask
    function automatic int unsigned burst_beats(logic [`L2_BURST_W-1:0] mask);
        return int'(mask) + 1;
    endfunction

endpackage

//--- src/req_fifo.sv
// *************************************************************************
// Synchronous queue
// Circular buffer with occupancy count, head entry always on data_out
// *************************************************************************

`timescale 1ns/1ps

`include "l2_bridge_defs.svh"

module req_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `L2_FIFO_DEPTH
) (
    input logic     clk,
    input logic     rst_n,
    fifo_if.storage q
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t          mem [DEPTH];   // Entry storage
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;         // Entries currently held

    // Flags come straight off the count register
    assign q.full     = (count == CNT_W'(DEPTH));
    assign q.valid    = (count != '0);
    assign q.data_out = mem[rd_ptr];  // Head entry

    always_ff @(posedge clk) begin
        if (q.push) begin
            mem[wr_ptr] <= q.data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (q.push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap
            end
            if (q.pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({q.push, q.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Idle or push with pop
            endcase
        end
    end

    // Producer must honor full
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        q.push |-> !q.full);

    // Consumer pops only a live head
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        q.pop |-> q.valid);

endmodule

//--- src/wb_burst_master.sv
// *************************************************************************
// Wishbone burst engine
// Turns the head request into wrapped classic single-beat cycles
// and registers the read return
// *************************************************************************

`timescale 1ns/1ps

`include "l2_bridge_defs.svh"

module wb_burst_master
    import l2_bridge_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    fifo_if.consumer              req,          // Request queue head
    fifo_if.consumer              wd,           // Write-data queue head
    output logic                  cyc,
    output logic                  stb,
    output logic                  we,
    output logic [`L2_ADDR_W-1:0] adr,
    output logic [`L2_BE_W-1:0]   sel,
    output logic [`L2_DATA_W-1:0] dat_w,
    input  logic                  ack,
    input  logic [`L2_DATA_W-1:0] dat_r,
    output l2_rd_return_t         rd_ret,
    output logic                  rd_ret_valid
);

    l2_request_t             head;           // Request being serviced
    l2_wr_data_t             wbeat;          // Next write beat
    logic [`L2_BURST_W-1:0]  burst_count;    // Beats acked so far
    logic [`L2_BURST_W-1:0]  beat_low;       // Wrapped low address bits
    logic                    beat_done;
    logic                    last_beat;

    assign head  = req.data_out;
    assign wbeat = wd.data_out;

    assign beat_done = stb & ack;                        // Transfer completes
    assign last_beat = (burst_count == head.burst_size);

    // Beat counter restarts with each new request
    always_ff @(posedge clk) begin
        if (!rst_n || req.pop) begin
            burst_count <= '0;
        end else if (beat_done) begin
            burst_count <= burst_count + 1'b1;
        end
    end

    // Keep bits outside the mask, count inside it
    assign beat_low = (head.addr[`L2_BURST_W-1:0] & ~head.burst_size)
                    | (burst_count & head.burst_size);
    assign adr = {head.addr[`L2_ADDR_W-1:`L2_BURST_W], beat_low};

    // One classic cycle per beat, held while the queue has work
    assign cyc   = req.valid;
    assign stb   = req.valid;
    assign we    = req.valid & ~head.rnw;
    assign sel   = head.rnw ? '1 : wbeat.be;     // Reads take the full word
    assign dat_w = wbeat.data;

    assign wd.pop  = beat_done & we;             // One data beat per write ack
    assign req.pop = beat_done & last_beat;      // Retire on final ack

    // Return path, valid one cycle after a read ack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ret_valid <= 1'b0;
        end else begin
            rd_ret_valid <= beat_done & head.rnw;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_done && head.rnw) begin
            rd_ret.data   <= dat_r;
            rd_ret.sub_id <= head.sub_id;        // Tag of the owning request
        end
    end

    // Slave may only ack a strobed cycle
    a_ack_with_stb: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> stb);

    // Requester must queue write data ahead of use
    a_wr_data_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (stb && we) |-> wd.valid);

    // Burst size must be a low-bit mask
    a_burst_mask: assert property (@(posedge clk) disable iff (!rst_n)
        stb |-> ((head.burst_size & (head.burst_size + 1'b1)) == '0));

endmodule

//--- test/tb_l1_wb_bridge.sv
// *************************************************************************
// L1-to-Wishbone bridge testbench
// Drives both queues, checks read returns against a shadow memory
// and compares the slave memory at the end of the write tests
// *************************************************************************

`timescale 1ns/1ps

`include "l2_bridge_defs.svh"

module tb_l1_wb_bridge
    import l2_bridge_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int MEM_WORDS   = 256;
    localparam int MAX_STALL   = 3;        // Longest random stall run
    localparam int IDLE_LIMIT  = 4000;     // Cycles to wait for a drain
    localparam int N_SINGLE    = 16;
    localparam int N_WBURST    = 8;
    localparam int N_MIX       = 40;
    localparam int TOTAL_BEATS = N_SINGLE + 2 * N_SINGLE      // Single reads, writes, read-back
                               + 2 * 63                       // Every read burst size twice
                               + N_WBURST * 33                // Write bursts and blockers
                               + `L2_FIFO_DEPTH               // Queue-full reads
                               + N_MIX * 8 + MEM_WORDS;       // Mix and final read-back
    localparam int WATCHDOG_NS = TOTAL_BEATS * (MAX_STALL + 4) * CLK_PERIOD + 50000;

    logic                    clk;
    logic                    rst_n;
    logic                    req_push;
    logic [`L2_ADDR_W-1:0]   req_addr;
    logic                    req_rnw;
    logic [`L2_BURST_W-1:0]  req_burst_size;
    logic [`L2_SUB_ID_W-1:0] req_sub_id;
    logic                    req_full;
    logic                    wr_push;
    logic [`L2_DATA_W-1:0]   wr_data;
    logic [`L2_BE_W-1:0]     wr_be;
    logic                    wr_full;
    logic                    rd_valid;
    logic [`L2_DATA_W-1:0]   rd_data;
    logic [`L2_SUB_ID_W-1:0] rd_sub_id;
    logic                    cyc, stb, we, ack;
    logic [`L2_ADDR_W-1:0]   adr;
    logic [`L2_BE_W-1:0]     sel;
    logic [`L2_DATA_W-1:0]   dat_w, dat_r;
    logic                    stall_force = 1'b0;   // Hold the slave off entirely
    logic                    stall_en    = 1'b0;   // Allow random stalls
    logic                    stall_rand  = 1'b0;
    logic                    stall;

    logic [15:0]             stim_lfsr  = 16'd29335;
    logic [15:0]             stall_lfsr = 16'd29335;
    logic [`L2_DATA_W-1:0]   shadow [MEM_WORDS];   // Reference copy of the slave
    l2_rd_return_t           exp_q [$];            // Predicted returns in order
    string                   cur_test = "reset";
    int                      test_errors, total_errors, tests_run, tests_failed;
    int                      checks, returns_seen;

    assign stall = stall_force | stall_rand;

    l1_wb_bridge u_dut (
        .clk(clk), .rst_n(rst_n),
        .req_push(req_push), .req_addr(req_addr), .req_rnw(req_rnw),
        .req_burst_size(req_burst_size), .req_sub_id(req_sub_id), .req_full(req_full),
        .wr_push(wr_push), .wr_data(wr_data), .wr_be(wr_be), .wr_full(wr_full),
        .rd_valid(rd_valid), .rd_data(rd_data), .rd_sub_id(rd_sub_id),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .sel(sel), .dat_w(dat_w),
        .ack(ack), .dat_r(dat_r)
    );

    wb_mem_model u_mem (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .sel(sel), .dat_w(dat_w), .ack(ack), .dat_r(dat_r), .stall(stall)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [`L2_BURST_W-1:0] mask_of(input int n);
        return `L2_BURST_W'((1 << n) - 1);       // 2^n beats
    endfunction

    function automatic logic [`L2_DATA_W-1:0] preload_word(input int i);
        return {8'(i), 8'(i) ^ 8'h3c, ~8'(i), 8'(i * 7)};
    endfunction

    function automatic logic [`L2_DATA_W-1:0] merge_bytes(input logic [`L2_DATA_W-1:0] old_w,
            input logic [`L2_DATA_W-1:0] new_w, input logic [`L2_BE_W-1:0] be);
        logic [`L2_DATA_W-1:0] m;
        m = old_w;
        for (int b = 0; b < `L2_BE_W; b++) begin
            if (be[b]) begin
                m[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return m;
    endfunction

    // Reference for one beat that also updates the shadow on writes
    function automatic l2_rd_return_t model_beat(input l2_request_t r, input int k,
            input l2_wr_data_t w);
        int            start;
        int            beats;
        logic [7:0]    idx;
        l2_rd_return_t ret;
        start = int'(r.addr[7:0]);
        beats = int'(r.burst_size) + 1;
        idx   = 8'(start - (start % beats) + k);   // Beat k sits at offset k of its block
        if (!r.rnw) begin
            shadow[idx] = merge_bytes(shadow[idx], w.data, w.be);
        end
        ret.data   = shadow[idx];
        ret.sub_id = r.sub_id;
        return ret;
    endfunction

    task automatic check_read(input l2_rd_return_t exp, input l2_rd_return_t act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH %s: expected data=%h sub_id=%0d, actual data=%h sub_id=%0d",
                     cur_test, exp.data, exp.sub_id, act.data, act.sub_id);
            test_errors++;
        end
    endtask

    task automatic check_word(input logic [`L2_ADDR_W-1:0] addr,
                              input logic [`L2_DATA_W-1:0] data);
        logic [`L2_DATA_W-1:0] act;
        act = u_mem.mem[addr[7:0]];
        checks++;
        if (act !== data) begin
            $display("MISMATCH %s: word %0d expected %h actual %h",
                     cur_test, addr[7:0], data, act);
            test_errors++;
        end
    endtask

    task automatic check_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_word(`L2_ADDR_W'(i), shadow[i]);
        end
    endtask

    // Return checker on the falling edge
    always @(negedge clk) begin : compare_returns
        l2_rd_return_t act;
        if (rst_n && rd_valid) begin
            act.data   = rd_data;
            act.sub_id = rd_sub_id;
            returns_seen++;
            if (exp_q.size() == 0) begin
                $display("ERROR %s: read return arrived with nothing expected", cur_test);
                test_errors++;
            end else begin
                check_read(exp_q.pop_front(), act);
            end
        end
    end

    // Every read beat strobes the full word
    always @(negedge clk) begin : read_sel_monitor
        if (rst_n && stb && ack && !we) begin
            checks++;
            if (sel !== {`L2_BE_W{1'b1}}) begin
                $display("MISMATCH %s: read sel expected %h actual %h",
                         cur_test, {`L2_BE_W{1'b1}}, sel);
                test_errors++;
            end
        end
    end

    initial begin : stall_gen
        int run;
        run = 0;
        forever begin
            @(posedge clk);
            #2;
            stall_lfsr = lfsr_step(stall_lfsr);              // One bit per cycle
            if (stall_en && stall_lfsr[0] && run < MAX_STALL) begin
                stall_rand = 1'b1;
                run++;
            end else begin
                stall_rand = 1'b0;
                run = 0;
            end
        end
    end

    task automatic push_request(input l2_request_t r);
        while (req_full) begin
            @(posedge clk);
            #2;
        end
        req_push       = 1'b1;
        req_addr       = r.addr;
        req_rnw        = r.rnw;
        req_burst_size = r.burst_size;
        req_sub_id     = r.sub_id;
        @(posedge clk);
        #2;
        req_push = 1'b0;
    endtask

    task automatic push_wdata(input l2_wr_data_t w);
        while (wr_full) begin
            @(posedge clk);
            #2;
        end
        wr_push = 1'b1;
        wr_data = w.data;
        wr_be   = w.be;
        @(posedge clk);
        #2;
        wr_push = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((cyc || exp_q.size() != 0) && n < IDLE_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (n >= IDLE_LIMIT) begin
            $display("ERROR %s: bus still busy with %0d reads outstanding after %0d cycles",
                     cur_test, exp_q.size(), IDLE_LIMIT);
            test_errors++;
        end
    endtask

    task automatic issue_read(input logic [`L2_ADDR_W-1:0] addr,
                              input logic [`L2_BURST_W-1:0] mask);
        l2_request_t r;
        l2_wr_data_t none;
        r.addr       = addr;
        r.rnw        = 1'b1;
        r.burst_size = mask;
        r.sub_id     = `L2_SUB_ID_W'(rand_bits(2));
        none         = '0;
        for (int k = 0; k <= int'(mask); k++) begin
            exp_q.push_back(model_beat(r, k, none));
        end
        push_request(r);
    endtask

    task automatic issue_write(input logic [`L2_ADDR_W-1:0] addr,
                               input logic [`L2_BURST_W-1:0] mask, input bit data_first);
        l2_request_t r;
        l2_wr_data_t w;
        l2_wr_data_t beats [$];
        r.addr       = addr;
        r.rnw        = 1'b0;
        r.burst_size = mask;
        r.sub_id     = `L2_SUB_ID_W'(rand_bits(2));
        for (int k = 0; k <= int'(mask); k++) begin
            w.data = rand_bits(32);
            w.be   = `L2_BE_W'(rand_bits(4));
            beats.push_back(w);
            void'(model_beat(r, k, w));
        end
        if (data_first) begin
            foreach (beats[k]) push_wdata(beats[k]);
            push_request(r);
        end else begin
            wait_idle();                                   // Room for all the beats
            stall_force = 1'b1;
            issue_read(addr ^ `L2_ADDR_W'(32), '0);        // Blocker keeps the write off the head
            push_request(r);
            foreach (beats[k]) push_wdata(beats[k]);
            stall_force = 1'b0;
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        wait_idle();
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %-14s errors %0d", cur_test, test_errors);
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("ERROR watchdog expired after %0d ns during %s", WATCHDOG_NS, cur_test);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : main
        logic [`L2_ADDR_W-1:0] addrs [$];
        int                    base;
        rst_n = 1'b0;
        req_push = 1'b0;
        req_addr = '0;
        req_rnw = 1'b0;
        req_burst_size = '0;
        req_sub_id = '0;
        wr_push = 1'b0;
        wr_data = '0;
        wr_be = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = preload_word(i);
        end
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        start_test("single_read");
        if (cyc || stb || rd_valid || req_full || wr_full) begin
            $display("ERROR %s: bus or queue flags active after reset", cur_test);
            test_errors++;
        end
        for (int i = 0; i < N_SINGLE; i++) issue_read(`L2_ADDR_W'(rand_bits(30)), '0);
        end_test();

        start_test("single_write");
        for (int i = 0; i < N_SINGLE; i++) begin
            addrs.push_back(`L2_ADDR_W'(rand_bits(30)));
            issue_write(addrs[i], '0, 1'b1);
        end
        foreach (addrs[i]) issue_read(addrs[i], '0);       // Read back
        wait_idle();
        foreach (addrs[i]) check_word(addrs[i], shadow[addrs[i][7:0]]);
        end_test();

        start_test("read_burst");
        for (int pass = 0; pass < 2; pass++) begin
            for (int s = 0; s < 6; s++) issue_read(`L2_ADDR_W'(rand_bits(30)), mask_of(s));
        end
        end_test();

        start_test("write_burst");
        for (int i = 0; i < N_WBURST; i++) begin
            issue_write(`L2_ADDR_W'(rand_bits(30)), mask_of(int'(rand_bits(3)) % 6), i % 2 == 0);
        end
        wait_idle();
        check_memory();
        end_test();

        start_test("queue_full");
        stall_force = 1'b1;                                // Slave holds every beat
        base = returns_seen;
        for (int i = 0; i < `L2_FIFO_DEPTH; i++) begin
            if (req_full) begin
                $display("ERROR %s: req_full high with only %0d requests queued", cur_test, i);
                test_errors++;
            end
            issue_read(`L2_ADDR_W'(rand_bits(30)), '0);
        end
        if (!req_full) begin
            $display("ERROR %s: req_full low with the request queue at depth", cur_test);
            test_errors++;
        end
        stall_force = 1'b0;
        wait_idle();
        if (returns_seen - base != `L2_FIFO_DEPTH) begin
            $display("ERROR %s: %0d of %0d reads returned", cur_test,
                     returns_seen - base, `L2_FIFO_DEPTH);
            test_errors++;
        end
        end_test();

        start_test("random_mix");
        stall_en = 1'b1;
        for (int i = 0; i < N_MIX; i++) begin
            if (rand_bits(1) != 0) begin
                issue_read(`L2_ADDR_W'(rand_bits(30)), mask_of(int'(rand_bits(2))));
            end else begin
                issue_write(`L2_ADDR_W'(rand_bits(30)), mask_of(int'(rand_bits(2))), 1'b1);
            end
        end
        for (int b = 0; b < MEM_WORDS / 32; b++) issue_read(`L2_ADDR_W'(b * 32), 5'd31);
        wait_idle();
        stall_en = 1'b0;
        check_memory();
        end_test();

        $display("tests %0d run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, total_errors);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- test/wb_mem_model.sv
// *************************************************************************
// Wishbone slave memory model
// 256-word memory with byte lanes, registered ack and a stall input
// *************************************************************************

`timescale 1ns/1ps

`include "l2_bridge_defs.svh"

module wb_mem_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  logic [`L2_ADDR_W-1:0] adr,
    input  logic [`L2_BE_W-1:0]   sel,
    input  logic [`L2_DATA_W-1:0] dat_w,
    output logic                  ack,
    output logic [`L2_DATA_W-1:0] dat_r,
    input  logic                  stall     // Holds off ack while high
);

    logic [`L2_DATA_W-1:0] mem [256];      // Word storage
    logic [7:0]            idx;            // Low address bits only
    logic                  take;           // Accept the strobed beat now

    assign idx  = adr[7:0];
    assign take = cyc && stb && !ack && !stall;   // One ack per beat

    // Every byte depends on the whole index
    function automatic logic [`L2_DATA_W-1:0] preload_word(input int i);
        return {8'(i), 8'(i) ^ 8'h3c, ~8'(i), 8'(i * 7)};
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = preload_word(i);
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= take;
        end
        if (take) begin
            dat_r <= mem[idx];             // Read word lines up with ack
        end
        if (cyc && stb && we && ack) begin
            for (int b = 0; b < `L2_BE_W; b++) begin
                if (sel[b]) begin
                    mem[idx][8*b +: 8] <= dat_w[8*b +: 8];   // Enabled lanes only
                end
            end
        end
    end

endmodule

//--- vlog.f
+incdir+src
src/l2_bridge_pkg.sv
src/fifo_if.sv
src/req_fifo.sv
src/wb_burst_master.sv
src/l1_wb_bridge.sv
test/wb_mem_model.sv
test/tb_l1_wb_bridge.sv
